//--- hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;

    typedef logic [xlen-1:0]      word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // bus size code, log2 of the byte count
    localparam logic [1:0] size_word = 2'd2;

    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_op_imm = 7'b0010011,
        opc_auipc  = 7'b0010111,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011,
        opc_jalr   = 7'b1100111,
        opc_jal    = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // writeback source for rd
    typedef enum logic [1:0] {
        wb_alu,
        wb_pc4,
        wb_imm,
        wb_load
    } wb_sel_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_idx_t    rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_idx_t   rd;
        opcode_t    opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef struct packed {
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        logic       rd_we;
        alu_op_t    alu_op;
        logic       src_pc;
        logic       src_imm;
        logic       branch;
        logic [2:0] funct3;
        logic       jump;
        logic       jalr;
        logic       load;
        logic       store;
        wb_sel_t    rd_sel;
    } ctrl_t;

    typedef struct packed {
        word_t      addr;
        word_t      wdata;
        logic       write;
        logic [1:0] size;
    } mem_req_t;

endpackage

`default_nettype wire

//--- hdl/rv_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module rv_fetch import rv_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic     inst_selfdefine,
    input  logic     reset,
    input  logic     retire,
    input  logic     take_branch,
    input  logic     jump,
    input  word_t    target,
    output logic     ibus_valid,
    input  logic     ibus_ready,
    output mem_req_t ibus_req,
    input  word_t    ibus_rdata,
    output word_t    pc,
    output inst_u    inst,
    output logic     inst_valid
);

    typedef enum logic [1:0] {
        fs_boot,
        fs_req,
        fs_exec
    } fetch_state_t;

    fetch_state_t state;
    word_t        next_pc;

    assign next_pc = (jump | take_branch) ? target : pc + 32'd4;

    // request is held while in fs_req, pc does not move there
    assign ibus_valid     = (state == fs_req);
    assign ibus_req.addr  = pc;
    assign ibus_req.wdata = '0;
    assign ibus_req.write = 1'b0;
    assign ibus_req.size  = size_word;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            state      <= fs_boot;
            pc         <= RESET_PC;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= 1'b0;
            case (state)
                fs_boot: begin
                    state <= fs_req;
                end
                fs_req: begin
                    if (ibus_ready) begin
                        inst_valid <= 1'b1;
                        state      <= fs_exec;
                    end
                end
                fs_exec: begin
                    if (retire) begin
                        pc    <= next_pc;
                        state <= fs_req;
                    end
                end
                default: begin
                    state <= fs_boot;
                end
            endcase
        end
    end

    // instruction word, held until the next fetch completes
    always_ff @(posedge inst_selfdefine) begin
        if (ibus_valid && ibus_ready) begin
            inst <= ibus_rdata;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rv_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decode import rv_pkg::*; (
    input  inst_u inst,
    output ctrl_t ctrl,
    output word_t imm
);

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // funct3 to alu op, alt selects sub / sra
    function automatic alu_op_t alu_func(input logic [2:0] funct3, input logic alt);
        alu_op_t op;
        case (funct3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
    assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
    assign imm_b = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                    inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {inst.u_fmt.imm, 12'd0};
    assign imm_j = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                    inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        ctrl        = '0;
        ctrl.rs1    = inst.r_fmt.rs1;
        ctrl.rs2    = inst.r_fmt.rs2;
        ctrl.rd     = inst.r_fmt.rd;
        ctrl.funct3 = inst.r_fmt.funct3;
        imm         = '0;
        case (inst.r_fmt.opcode)
            opc_op: begin
                ctrl.rd_we  = 1'b1;
                ctrl.alu_op = alu_func(inst.r_fmt.funct3, inst.r_fmt.funct7[5]);
            end
            opc_op_imm: begin
                ctrl.rd_we   = 1'b1;
                ctrl.src_imm = 1'b1;
                // bit 30 only matters for srai
                ctrl.alu_op  = alu_func(inst.i_fmt.funct3,
                    (inst.i_fmt.funct3 == 3'b101) && inst.r_fmt.funct7[5]);
                imm          = imm_i;
            end
            opc_lui: begin
                ctrl.rd_we  = 1'b1;
                ctrl.rd_sel = wb_imm;
                imm         = imm_u;
            end
            opc_auipc: begin
                ctrl.rd_we   = 1'b1;
                ctrl.src_pc  = 1'b1;
                ctrl.src_imm = 1'b1;
                imm          = imm_u;
            end
            opc_jal: begin
                ctrl.rd_we   = 1'b1;
                ctrl.src_pc  = 1'b1;
                ctrl.src_imm = 1'b1;
                ctrl.jump    = 1'b1;
                ctrl.rd_sel  = wb_pc4;
                imm          = imm_j;
            end
            opc_jalr: begin
                ctrl.rd_we   = 1'b1;
                ctrl.src_imm = 1'b1;
                ctrl.jump    = 1'b1;
                ctrl.jalr    = 1'b1;
                ctrl.rd_sel  = wb_pc4;
                imm          = imm_i;
            end
            opc_branch: begin
                ctrl.src_pc  = 1'b1;
                ctrl.src_imm = 1'b1;
                ctrl.branch  = 1'b1;
                imm          = imm_b;
            end
            opc_load: begin
                ctrl.rd_we   = 1'b1;
                ctrl.src_imm = 1'b1;
                ctrl.load    = 1'b1;
                ctrl.rd_sel  = wb_load;
                imm          = imm_i;
            end
            opc_store: begin
                ctrl.src_imm = 1'b1;
                ctrl.store   = 1'b1;
                imm          = imm_s;
            end
            default: begin
                // unknown opcode retires without effect
                ctrl.rd_we = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
    input  logic     inst_selfdefine,
    input  logic     reset,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     we,
    input  reg_idx_t rd,
    input  word_t    rd_data
);

    // x0 has no storage
    word_t regs [1:31];

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= rd_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rv_alu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_alu import rv_pkg::*; (
    input  ctrl_t ctrl,
    input  word_t pc,
    input  word_t rs1_data,
    input  word_t rs2_data,
    input  word_t imm,
    output word_t result,
    output logic  take_branch
);

    word_t      op_a;
    word_t      op_b;
    word_t      raw;
    logic [4:0] shamt;
    logic       cond;

    assign op_a  = ctrl.src_pc ? pc : rs1_data;
    assign op_b  = ctrl.src_imm ? imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            alu_add:  raw = op_a + op_b;
            alu_sub:  raw = op_a - op_b;
            alu_sll:  raw = op_a << shamt;
            alu_slt:  raw = {31'd0, $signed(op_a) < $signed(op_b)};
            alu_sltu: raw = {31'd0, op_a < op_b};
            alu_xor:  raw = op_a ^ op_b;
            alu_srl:  raw = op_a >> shamt;
            alu_sra:  raw = word_t'($signed(op_a) >>> shamt);
            alu_or:   raw = op_a | op_b;
            alu_and:  raw = op_a & op_b;
            default:  raw = op_a + op_b;
        endcase
    end

    // jalr target has bit 0 cleared
    assign result = {raw[31:1], raw[0] & ~ctrl.jalr};

    always_comb begin
        case (ctrl.funct3)
            3'b000:  cond = (rs1_data == rs2_data);
            3'b001:  cond = (rs1_data != rs2_data);
            3'b100:  cond = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  cond = (rs1_data < rs2_data);
            3'b111:  cond = (rs1_data >= rs2_data);
            default: cond = 1'b0;
        endcase
    end

    assign take_branch = ctrl.branch & cond;

endmodule

`default_nettype wire

//--- hdl/rv_lsu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_lsu import rv_pkg::*; (
    input  logic     inst_selfdefine,
    input  logic     reset,
    input  logic     inst_valid,
    input  ctrl_t    ctrl,
    input  word_t    addr,
    input  word_t    wdata,
    output logic     dbus_valid,
    input  logic     dbus_ready,
    output mem_req_t dbus_req,
    input  word_t    dbus_rdata,
    output word_t    load_data,
    output logic     lsu_done
);

    word_t addr_q;
    word_t wdata_q;
    logic  write_q;
    logic  mem_inst;

    assign mem_inst = ctrl.load | ctrl.store;

    // word accesses only
    assign dbus_req.addr  = addr_q;
    assign dbus_req.wdata = wdata_q;
    assign dbus_req.write = write_q;
    assign dbus_req.size  = size_word;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            dbus_valid <= 1'b0;
            lsu_done   <= 1'b0;
        end else begin
            lsu_done <= dbus_valid & dbus_ready;
            if (inst_valid && mem_inst) begin
                dbus_valid <= 1'b1;
            end else if (dbus_ready) begin
                dbus_valid <= 1'b0;
            end
        end
    end

    // request payload, stable until ready
    always_ff @(posedge inst_selfdefine) begin
        if (inst_valid && mem_inst) begin
            addr_q  <= addr;
            wdata_q <= wdata;
            write_q <= ctrl.store;
        end
    end

    always_ff @(posedge inst_selfdefine) begin
        if (dbus_valid && dbus_ready) begin
            load_data <= dbus_rdata;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core import rv_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic     inst_selfdefine,
    input  logic     reset,
    output logic     ibus_valid,
    input  logic     ibus_ready,
    output mem_req_t ibus_req,
    input  word_t    ibus_rdata,
    output logic     dbus_valid,
    input  logic     dbus_ready,
    output mem_req_t dbus_req,
    input  word_t    dbus_rdata
);

    word_t pc;
    inst_u inst;
    logic  inst_valid;
    ctrl_t ctrl;
    word_t imm;
    word_t rs1_data;
    word_t rs2_data;
    word_t alu_result;
    logic  take_branch;
    word_t load_data;
    logic  lsu_done;
    logic  exec_q;
    logic  retire;
    word_t rd_data;

    // non-memory instructions retire one cycle after decode
    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            exec_q <= 1'b0;
        end else begin
            exec_q <= inst_valid & ~(ctrl.load | ctrl.store);
        end
    end

    assign retire = exec_q | lsu_done;

    always_comb begin
        case (ctrl.rd_sel)
            wb_pc4:  rd_data = pc + 32'd4;
            wb_imm:  rd_data = imm;
            wb_load: rd_data = load_data;
            default: rd_data = alu_result;
        endcase
    end

    rv_fetch #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .inst_selfdefine(inst_selfdefine),
        .reset(reset),
        .retire(retire),
        .take_branch(take_branch),
        .jump(ctrl.jump),
        .target(alu_result),
        .ibus_valid(ibus_valid),
        .ibus_ready(ibus_ready),
        .ibus_req(ibus_req),
        .ibus_rdata(ibus_rdata),
        .pc(pc),
        .inst(inst),
        .inst_valid(inst_valid)
    );

    rv_decode u_decode (
        .inst(inst),
        .ctrl(ctrl),
        .imm(imm)
    );

    rv_regfile u_regfile (
        .inst_selfdefine(inst_selfdefine),
        .reset(reset),
        .rs1(ctrl.rs1),
        .rs2(ctrl.rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .we(retire & ctrl.rd_we),
        .rd(ctrl.rd),
        .rd_data(rd_data)
    );

    rv_alu u_alu (
        .ctrl(ctrl),
        .pc(pc),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .imm(imm),
        .result(alu_result),
        .take_branch(take_branch)
    );

    rv_lsu u_lsu (
        .inst_selfdefine(inst_selfdefine),
        .reset(reset),
        .inst_valid(inst_valid),
        .ctrl(ctrl),
        .addr(alu_result),
        .wdata(rs2_data),
        .dbus_valid(dbus_valid),
        .dbus_ready(dbus_ready),
        .dbus_req(dbus_req),
        .dbus_rdata(dbus_rdata),
        .load_data(load_data),
        .lsu_done(lsu_done)
    );

endmodule

`default_nettype wire

//--- sim/rv_core_chk.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_chk import rv_pkg::*; (
    input logic     inst_selfdefine,
    input logic     reset,
    input logic     ibus_valid,
    input logic     ibus_ready,
    input mem_req_t ibus_req,
    input logic     dbus_valid,
    input logic     dbus_ready,
    input mem_req_t dbus_req
);

    // request held while the bus stalls
    ibus_stable: assert property (@(posedge inst_selfdefine) disable iff (reset)
        (ibus_valid && !ibus_ready) |=> (ibus_valid && $stable(ibus_req)))
        else $error("ibus request changed during back-pressure");

    dbus_stable: assert property (@(posedge inst_selfdefine) disable iff (reset)
        (dbus_valid && !dbus_ready) |=> (dbus_valid && $stable(dbus_req)))
        else $error("dbus request changed during back-pressure");

    reset_idle: assert property (@(posedge inst_selfdefine)
        reset |=> (!ibus_valid && !dbus_valid))
        else $error("bus valid high right after reset");

    word_size: assert property (@(posedge inst_selfdefine) disable iff (reset)
        dbus_valid |-> (dbus_req.size == size_word && dbus_req.addr[1:0] == 2'b00))
        else $error("dbus access is not an aligned word");

endmodule

bind rv_core rv_core_chk u_chk (
    .inst_selfdefine(inst_selfdefine),
    .reset(reset),
    .ibus_valid(ibus_valid),
    .ibus_ready(ibus_ready),
    .ibus_req(ibus_req),
    .dbus_valid(dbus_valid),
    .dbus_ready(dbus_ready),
    .dbus_req(dbus_req)
);

`default_nettype wire

//--- sim/tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

    // addi x4, x0, 2047, sits only on paths that must be skipped
    localparam word_t poison = 32'h7ff0_0213;

    logic     inst_selfdefine = 1'b0;
    logic     reset = 1'b1;
    logic     ibus_valid;
    logic     ibus_ready = 1'b0;
    mem_req_t ibus_req;
    word_t    ibus_rdata = '0;
    logic     dbus_valid;
    logic     dbus_ready = 1'b0;
    mem_req_t dbus_req;
    word_t    dbus_rdata = '0;

    word_t prog[$];
    word_t exp_fetch[$];
    word_t exp_addr[$];
    word_t exp_data[$];
    word_t preload[0:31];
    word_t dmem[0:31];
    word_t st_off = '0;
    word_t mark;
    word_t a;
    word_t b;
    int    fetch_idx = 0;
    int    store_idx = 0;
    int    fetch_wait = 0;
    int    data_wait = 0;
    int    fetch_errors = 0;
    int    store_errors = 0;
    int    run_errors = 0;
    int    cycles = 0;
    int    limit;

    rv_core #(
        .RESET_PC(32'h0000_0000)
    ) u_dut (
        .inst_selfdefine(inst_selfdefine),
        .reset(reset),
        .ibus_valid(ibus_valid),
        .ibus_ready(ibus_ready),
        .ibus_req(ibus_req),
        .ibus_rdata(ibus_rdata),
        .dbus_valid(dbus_valid),
        .dbus_ready(dbus_ready),
        .dbus_req(dbus_req),
        .dbus_rdata(dbus_rdata)
    );

    initial begin
        forever #4 inst_selfdefine = ~inst_selfdefine;
    end

    task automatic compare(input string what, input word_t got, input word_t want,
                           inout int count);
        if (got !== want) begin
            count++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    function automatic word_t op_rr(input logic [2:0] f3, input logic [6:0] f7,
                                    input reg_idx_t rd, input reg_idx_t rs1,
                                    input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t op_ri(input logic [2:0] f3, input reg_idx_t rd,
                                    input reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t u_inst(input logic [6:0] opc, input reg_idx_t rd,
                                     input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic word_t jal_inst(input reg_idx_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t here();
        return word_t'(prog.size() * 4);
    endfunction

    // out of range fetches read as nop
    function automatic word_t instr_at(input word_t addr);
        int slot;
        slot = int'(addr >> 2);
        if (slot < prog.size()) begin
            return prog[slot];
        end
        return 32'h0000_0013;
    endfunction

    task automatic emit(input word_t w);
        exp_fetch.push_back(here());
        prog.push_back(w);
    endtask

    task automatic skip(input word_t w);
        prog.push_back(w);
    endtask

    // sw rs, st_off(x1)
    task automatic store_check(input reg_idx_t rs, input word_t value);
        emit({st_off[11:5], rs, 5'd1, 3'b010, st_off[4:0], 7'b0100011});
        exp_addr.push_back(32'h100 + st_off);
        exp_data.push_back(value);
        st_off = st_off + 32'd4;
    endtask

    task automatic op_check(input word_t w, input word_t value);
        emit(w);
        store_check(5'd4, value);
    endtask

    // forward branch by 8
    task automatic branch_check(input logic [2:0] f3, input reg_idx_t rs1,
                                input reg_idx_t rs2, input logic taken);
        emit({1'b0, 6'd0, rs2, rs1, f3, 4'd4, 1'b0, 7'b1100011});
        if (taken) begin
            skip(poison);
        end
    endtask

    task automatic build_program();
        emit(op_ri(3'b000, 5'd1, 5'd0, 12'h100));
        emit(op_ri(3'b000, 5'd2, 5'd0, 12'd25));
        emit(op_ri(3'b000, 5'd3, 5'd0, 12'hff9));
        op_check(op_ri(3'b000, 5'd4, 5'd2, 12'd100), a + 32'd100);
        op_check(op_rr(3'b000, 7'h00, 5'd4, 5'd2, 5'd3), a + b);
        op_check(op_rr(3'b000, 7'h20, 5'd4, 5'd3, 5'd2), b - a);
        op_check(op_rr(3'b100, 7'h00, 5'd4, 5'd2, 5'd3), a ^ b);
        op_check(op_rr(3'b110, 7'h00, 5'd4, 5'd2, 5'd3), a | b);
        op_check(op_rr(3'b111, 7'h00, 5'd4, 5'd2, 5'd3), a & b);
        // register shifts by 25
        op_check(op_rr(3'b001, 7'h00, 5'd4, 5'd3, 5'd2), b << 25);
        op_check(op_rr(3'b101, 7'h00, 5'd4, 5'd3, 5'd2), b >> 25);
        op_check(op_rr(3'b101, 7'h20, 5'd4, 5'd3, 5'd2), {{25{b[31]}}, b[31:25]});
        op_check(op_ri(3'b001, 5'd4, 5'd3, 12'd4), b << 4);
        op_check(op_ri(3'b101, 5'd4, 5'd3, 12'd4), b >> 4);
        op_check(op_ri(3'b101, 5'd4, 5'd3, 12'h404), {{4{b[31]}}, b[31:4]});
        // -7 against 25, signed then unsigned
        op_check(op_rr(3'b010, 7'h00, 5'd4, 5'd3, 5'd2), 32'd1);
        op_check(op_rr(3'b011, 7'h00, 5'd4, 5'd3, 5'd2), 32'd0);
        op_check(op_ri(3'b010, 5'd4, 5'd3, 12'd1), 32'd1);
        op_check(op_ri(3'b011, 5'd4, 5'd2, 12'hfff), 32'd1);
        op_check(op_ri(3'b100, 5'd4, 5'd2, 12'hfff), ~a);
        op_check(op_ri(3'b110, 5'd4, 5'd3, 12'h0f0), b | 32'h0f0);
        op_check(op_ri(3'b111, 5'd4, 5'd3, 12'h7f0), b & 32'h7f0);
        op_check(u_inst(7'b0110111, 5'd4, 20'habcde), 32'habcd_e000);
        op_check(u_inst(7'b0010111, 5'd4, 20'h00012), here() + 32'h12000);
        // lw x4, 124(x1) then addi -300
        emit({12'd124, 5'd1, 3'b010, 5'd4, 7'b0000011});
        op_check(op_ri(3'b000, 5'd4, 5'd4, 12'hed4), preload[31] - 32'd300);
        branch_check(3'b000, 5'd2, 5'd2, 1'b1);
        branch_check(3'b000, 5'd2, 5'd3, 1'b0);
        branch_check(3'b001, 5'd2, 5'd3, 1'b1);
        branch_check(3'b001, 5'd3, 5'd3, 1'b0);
        branch_check(3'b100, 5'd3, 5'd2, 1'b1);
        branch_check(3'b100, 5'd2, 5'd3, 1'b0);
        branch_check(3'b101, 5'd2, 5'd3, 1'b1);
        branch_check(3'b101, 5'd3, 5'd2, 1'b0);
        branch_check(3'b110, 5'd2, 5'd3, 1'b1);
        branch_check(3'b110, 5'd3, 5'd2, 1'b0);
        branch_check(3'b111, 5'd3, 5'd2, 1'b1);
        branch_check(3'b111, 5'd2, 5'd3, 1'b0);
        mark = here();
        emit(jal_inst(5'd4, 21'd8));
        skip(poison);
        store_check(5'd4, mark + 32'd4);
        // auipc x5, 0 then jalr x4, 13(x5), odd target lands on mark + 12
        mark = here();
        emit(u_inst(7'b0010111, 5'd5, 20'd0));
        emit({12'd13, 5'd5, 3'b000, 5'd4, 7'b1100111});
        skip(poison);
        store_check(5'd4, mark + 32'd8);
        emit(op_ri(3'b000, 5'd0, 5'd2, 12'd55));
        store_check(5'd0, 32'd0);
        emit(jal_inst(5'd0, 21'd0));
    endtask

    // instruction memory, random ready delay
    always @(posedge inst_selfdefine) begin
        if (reset) begin
            ibus_ready <= 1'b0;
        end else if (ibus_valid && ibus_ready) begin
            if (fetch_idx < exp_fetch.size()) begin
                compare("fetch address", ibus_req.addr, exp_fetch[fetch_idx], fetch_errors);
            end
            ibus_ready <= 1'b0;
            fetch_wait <= int'($urandom % 4);
            fetch_idx  <= fetch_idx + 1;
        end else if (ibus_valid) begin
            if (fetch_wait == 0) begin
                ibus_ready <= 1'b1;
                ibus_rdata <= instr_at(ibus_req.addr);
            end else begin
                fetch_wait <= fetch_wait - 1;
            end
        end
    end

    // data memory at 0x100, 32 words
    always @(posedge inst_selfdefine) begin
        if (reset) begin
            dbus_ready <= 1'b0;
            dmem       <= preload;
        end else if (dbus_valid && dbus_ready) begin
            if (dbus_req.write) begin
                if (store_idx < exp_addr.size()) begin
                    compare("store address", dbus_req.addr, exp_addr[store_idx],
                            store_errors);
                    compare("store data", dbus_req.wdata, exp_data[store_idx],
                            store_errors);
                end else begin
                    store_errors++;
                    $display("Unexpected extra store to address %h at %0t",
                             dbus_req.addr, $time);
                end
                dmem[dbus_req.addr[6:2]] <= dbus_req.wdata;
                store_idx <= store_idx + 1;
            end
            dbus_ready <= 1'b0;
            data_wait  <= int'($urandom % 4);
        end else if (dbus_valid) begin
            if (data_wait == 0) begin
                dbus_ready <= 1'b1;
                dbus_rdata <= dmem[dbus_req.addr[6:2]];
            end else begin
                data_wait <= data_wait - 1;
            end
        end
    end

    initial begin
        void'($urandom(32'h575a_783b));
        for (int i = 0; i < 32; i++) begin
            preload[i] = $urandom;
        end
        a = 32'd25;
        b = 32'hffff_fff9;
        build_program();
        limit = prog.size() * 12;
        // outputs are known after the first reset edge
        for (int i = 0; i < 5; i++) begin
            @(posedge inst_selfdefine);
            if (i > 0) begin
                compare("ibus_valid in reset", {31'd0, ibus_valid}, '0, run_errors);
                compare("dbus_valid in reset", {31'd0, dbus_valid}, '0, run_errors);
            end
        end
        reset <= 1'b0;
        while ((fetch_idx < exp_fetch.size() || store_idx < exp_addr.size())
               && cycles < limit) begin
            @(posedge inst_selfdefine);
            cycles++;
        end
        if (cycles >= limit) begin
            run_errors++;
            $display("Timeout: program did not complete within %0d cycles", limit);
        end
        @(negedge inst_selfdefine);
        $display("errors: fetch %0d, store %0d, other %0d",
                 fetch_errors, store_errors, run_errors);
        if (fetch_errors + store_errors + run_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
hdl/rv_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_lsu.sv
hdl/rv_core.sv
sim/rv_core_chk.sv
sim/tb_rv_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_rv_core
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SOURCES = $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
